// File: tests/edpCases.mem
// Columns: uWord cacheDataRead ebusIn diagFunc expected
// Bit 3 set in diagFunc skips the readback cycle
// With adToEbus set the expected value is the AD word seen one cycle later
00018006 000000000 000000000 0 000000000
00018006 000000000 000000000 2 000000000
00018006 000000000 000000000 3 000000000
00018406 48D17ABCD 3C3C15A5A 0 48D140000
00018A06 48D17ABCD 3C3C15A5A 0 48D155A5A
0001B006 000000000 000000000 1 48D155A5A
0001D008 000000000 000000000 4 48D155A5A
00018006 000000000 000000000 5 B72EAA5A5
002B8006 000000000 000000000 3 48D140000
00018C06 123456789 000000000 0 123456789
002D8006 000000000 000000000 3 48D156789
00819080 000000000 000000000 5 5B05AC1E4
00019091 000000000 000000000 5 12345678A
00019012 000000000 000000000 5 12345678B
00299003 000000000 000000000 5 001056789
00019084 000000000 000000000 5 5AF557FDB
00019085 000000000 000000000 5 5AE503DD3
00019008 000000000 000000000 5 EDCBA9876
0001D0C7 000000000 000000000 5 48D159E27
00019047 000000000 000000000 5 91A2AB4B5
00019D50 000000000 000000000 8 000000000
01019030 000000000 000000000 5 000000001
00000006 000000000 000000000 2 23455696A
00008031 000000000 000000000 2 468AAD2D5
00008006 000000000 000000000 2 8D155A5AA
00010006 000000000 000000000 2 C68AAD2D5
02018026 000000000 000000000 8 C68AAD2D5
00018006 000000000 000000000 0 23455696A
00018006 000000000 000000000 7 23455696A

// File: compile.f
+incdir+hdl
hdl/edpPkg.sv
hdl/microDecode.sv
hdl/operandRegs.sv
hdl/mqShifter.sv
hdl/fastMemory.sv
hdl/adderUnit.sv
hdl/ebusDriver.sv
hdl/edpTop.sv
tests/edpTb.sv

// File: runSim.sh
#!/bin/sh
# Build the EDP testbench with Verilator, run it, and check the log
verilator --binary --timing -f compile.f --top-module edpTb -o edpSim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/edpSim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }

// File: tests/edpTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module edpTb;

  localparam int NUM_CASES   = 29;
  localparam int CYCLE_LIMIT = 8 + 3 * NUM_CASES + 20;
  localparam int AD_TO_EBUS  = 25;
  // Pass-A with MQ hold, no register loads
  localparam logic [`EDP_UWORD_BITS-1:0] NOP_WORD     = 32'h0001_8006;
  localparam logic [`EDP_UWORD_BITS-1:0] FM_ADDR_MASK = 32'h0078_0000;
  // AR from cache, both halves
  localparam logic [`EDP_UWORD_BITS-1:0] LOAD_AR_WORD    = 32'h0001_8C06;
  // Same, and BR takes the old AR
  localparam logic [`EDP_UWORD_BITS-1:0] LOAD_AR_BR_WORD = 32'h0001_AC06;
  // ADA is AR, ADB is BR, function code in bits 3:0
  localparam logic [`EDP_UWORD_BITS-1:0] AR_BR_WORD      = 32'h0001_8080;
  localparam logic [`EDP_UWORD_BITS-1:0] FORCE_CARRY     = 32'h0080_0000;

  logic CLK;
  logic FPGA_RESET;
  logic [`EDP_UWORD_BITS-1:0] uWord;
  logic [0:`EDP_WORD_BITS-1] cacheDataRead, ebusIn, cacheDataWrite, ebusData;
  logic diagRead;
  logic [2:0] diagFunc;
  logic ebusDriving, adCarry, adOverflow, fmParity;

  // Five words per case
  logic [`EDP_WORD_BITS-1:0] caseMem [0:5*NUM_CASES-1];
  integer seed;
  integer cycleCount = 0;

  edpTop UUT (
    .CLK, .FPGA_RESET, .uWord, .cacheDataRead, .ebusIn, .diagRead, .diagFunc,
    .cacheDataWrite, .ebusData, .ebusDriving, .adCarry, .adOverflow, .fmParity
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("Simulation timed out after %0d cycles", cycleCount);
      $display("RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [`EDP_WORD_BITS-1:0] widenBit(input logic b);
    widenBit = '0;
    widenBit[0] = b;
  endfunction

  // Carry out of bit 0 and overflow of a + b + c
  function automatic logic [1:0] expectedFlags(input logic [`EDP_WORD_BITS-1:0] a,
                                               input logic [`EDP_WORD_BITS-1:0] b,
                                               input logic c);
    logic [`EDP_WORD_BITS:0] full;
    logic [`EDP_WORD_BITS-1:0] low;
    full = {1'b0, a} + {1'b0, b} + {{`EDP_WORD_BITS{1'b0}}, c};
    // Bits 1 to 35 alone give the carry into bit 0
    low  = {1'b0, a[`EDP_WORD_BITS-2:0]} + {1'b0, b[`EDP_WORD_BITS-2:0]}
           + {{(`EDP_WORD_BITS-1){1'b0}}, c};
    expectedFlags = {full[`EDP_WORD_BITS], full[`EDP_WORD_BITS] ^ low[`EDP_WORD_BITS-1]};
  endfunction

  task automatic checkValue(input string name, input logic [`EDP_WORD_BITS-1:0] actual,
                            input logic [`EDP_WORD_BITS-1:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %09h, expected %09h", $time, name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Flags are combinational, so look mid-cycle, then move to the next drive point
  task automatic sampleFlags(input logic carry, input logic overflow);
    @(negedge CLK);
    checkValue("adCarry", widenBit(adCarry), widenBit(carry));
    checkValue("adOverflow", widenBit(adOverflow), widenBit(overflow));
    @(posedge CLK);
    #1;
  endtask

  // BR gets b and AR gets a, then add, subtract and AND are applied
  task automatic flagSequence(input logic [`EDP_WORD_BITS-1:0] a,
                              input logic [`EDP_WORD_BITS-1:0] b, input logic cin);
    logic [1:0] flags;
    diagRead      = 1'b0;
    uWord         = LOAD_AR_WORD;
    cacheDataRead = b;
    @(posedge CLK);
    #1;
    uWord         = LOAD_AR_BR_WORD;
    cacheDataRead = a;
    @(posedge CLK);
    #1;
    uWord = cin ? (AR_BR_WORD | FORCE_CARRY) : AR_BR_WORD;
    flags = expectedFlags(a, b, cin);
    sampleFlags(flags[1], flags[0]);
    // Subtract adds one with no carry mode set
    uWord = AR_BR_WORD | 32'd1;
    flags = expectedFlags(a, ~b, 1'b1);
    sampleFlags(flags[1], flags[0]);
    uWord = AR_BR_WORD | 32'd3;
    sampleFlags(1'b0, 1'b0);
  endtask

  // Entered 1 ns after a rising edge
  task automatic runCase(input int idx);
    logic [`EDP_UWORD_BITS-1:0] word;
    logic [3:0] diagField;
    logic [`EDP_WORD_BITS-1:0] expected;
    logic [63:0] randBits;
    word          = caseMem[5*idx][`EDP_UWORD_BITS-1:0];
    diagField     = caseMem[5*idx+3][3:0];
    expected      = caseMem[5*idx+4];
    uWord         = word;
    cacheDataRead = caseMem[5*idx+1];
    ebusIn        = caseMem[5*idx+2];
    diagRead      = 1'b0;
    diagFunc      = diagField[2:0];
    @(posedge CLK);
    #1;
    // Bus is driven only when the microword strobed AD onto it
    checkValue("ebusDriving", widenBit(ebusDriving), widenBit(word[AD_TO_EBUS]));
    if (word[AD_TO_EBUS]) begin
      checkValue("ebusData", ebusData, expected);
    end else begin
      checkValue("ebusData", ebusData, '0);
    end
    if (!diagField[3]) begin
      // Readback cycle keeps the FM address of the case
      randBits = {$random(seed), $random(seed)};
      uWord    = NOP_WORD | (word & FM_ADDR_MASK);
      ebusIn   = randBits[`EDP_WORD_BITS-1:0];
      diagRead = 1'b1;
      @(posedge CLK);
      #1;
      checkValue("ebusDriving", widenBit(ebusDriving), widenBit(1'b1));
      checkValue("ebusData", ebusData, expected);
      // Cache write data mirrors AR
      if (diagField[2:0] == 3'd0) begin
        checkValue("cacheDataWrite", cacheDataWrite, expected);
      end
      if (diagField[2:0] == 3'd3) begin
        checkValue("fmParity", widenBit(fmParity), widenBit(^expected));
      end
    end
  endtask

  initial begin
    seed          = 59635;
    FPGA_RESET    = 1'b1;
    uWord         = NOP_WORD;
    cacheDataRead = '0;
    ebusIn        = '0;
    diagRead      = 1'b0;
    diagFunc      = 3'd0;
    $readmemh("tests/edpCases.mem", caseMem);
    repeat (8) @(posedge CLK);
    #1;
    FPGA_RESET = 1'b0;
    for (int i = 0; i < NUM_CASES; i++) begin
      runCase(i);
    end
    // Carry and overflow corners
    flagSequence(36'h400000000, 36'h400000000, 1'b0);
    flagSequence(36'h800000000, 36'h800000000, 1'b0);
    flagSequence(36'hFFFFFFFFF, 36'h000000000, 1'b1);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/edpTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module edpTop
  import edpPkg::*;
(
  input  wire logic                         CLK,
  input  wire logic                         FPGA_RESET,
  input  wire logic [`EDP_UWORD_BITS-1:0]   uWord,
  input  wire logic [0:`EDP_WORD_BITS-1]    cacheDataRead,
  input  wire logic [0:`EDP_WORD_BITS-1]    ebusIn,
  input  wire logic                         diagRead,
  input  wire logic [2:0]                   diagFunc,
  output logic      [0:`EDP_WORD_BITS-1]    cacheDataWrite,
  output logic      [0:`EDP_WORD_BITS-1]    ebusData,
  output logic                              ebusDriving,
  output logic                              adCarry,
  output logic                              adOverflow,
  output logic                              fmParity
);

  tAdFunc adFunc;
  tAdaSel adaSel;
  tAdbSel adbSel;
  tArSel  arSel;
  tMqFunc mqFunc;
  logic arlLoad, arrLoad, arxLoad, brLoad, brxLoad;
  logic fmWriteL, fmWriteR, carryIn, adToEbus;
  logic [`EDP_FM_ADDR_BITS-1:0] fmAddr;
  logic [0:`EDP_WORD_BITS-1] ar, arx, br, brx, mq, fm, ad;

  microDecode decode (
    .CLK, .FPGA_RESET, .uWord, .adCarry,
    .adFunc, .adaSel, .adbSel, .arSel,
    .arlLoad, .arrLoad, .arxLoad, .brLoad, .brxLoad,
    .mqFunc, .fmWriteL, .fmWriteR, .fmAddr,
    .carryIn, .adToEbus
  );

  operandRegs regs (
    .CLK, .FPGA_RESET, .arSel,
    .arlLoad, .arrLoad, .arxLoad, .brLoad, .brxLoad,
    .cacheDataRead, .ebusIn, .ad,
    .ar, .arx, .br, .brx
  );

  mqShifter mqReg (.CLK, .FPGA_RESET, .mqFunc, .ad, .adCarry, .mq);

  fastMemory fmem (
    .CLK, .FPGA_RESET, .fmAddr, .fmWriteL, .fmWriteR, .ar, .fm, .fmParity
  );

  adderUnit adder (
    .adFunc, .adaSel, .adbSel, .carryIn,
    .ar, .arx, .br, .brx, .mq, .fm,
    .ad, .adCarry, .adOverflow
  );

  ebusDriver ebus (
    .CLK, .FPGA_RESET, .diagRead, .diagFunc, .adToEbus,
    .ar, .br, .mq, .fm, .brx, .arx, .ad,
    .ebusData, .ebusDriving
  );

  // Cache write data comes straight from AR
  assign cacheDataWrite = ar;

endmodule

`default_nettype wire

// File: hdl/ebusDriver.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module ebusDriver
  import edpPkg::*;
(
  input  wire logic                       CLK,
  input  wire logic                       FPGA_RESET,
  input  wire logic                       diagRead,
  input  wire logic [2:0]                 diagFunc,
  input  wire logic                       adToEbus,
  input  wire logic [0:`EDP_WORD_BITS-1]  ar,
  input  wire logic [0:`EDP_WORD_BITS-1]  br,
  input  wire logic [0:`EDP_WORD_BITS-1]  mq,
  input  wire logic [0:`EDP_WORD_BITS-1]  fm,
  input  wire logic [0:`EDP_WORD_BITS-1]  brx,
  input  wire logic [0:`EDP_WORD_BITS-1]  arx,
  input  wire logic [0:`EDP_WORD_BITS-1]  ad,
  output logic      [0:`EDP_WORD_BITS-1]  ebusData,
  output logic                            ebusDriving
);

  tDiagSel diagSel;
  logic [0:`EDP_WORD_BITS-1] ebusR;

  // AD strobe overrides the diagnostic function
  assign diagSel = adToEbus ? diagAD : tDiagSel'(diagFunc);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      ebusR       <= '0;
      ebusDriving <= 1'b0;
    end else begin
      ebusDriving <= diagRead | adToEbus;
      if (diagRead | adToEbus) begin
        case (diagSel)
          diagAR:  ebusR <= ar;
          diagBR:  ebusR <= br;
          diagMQ:  ebusR <= mq;
          diagFM:  ebusR <= fm;
          diagBRX: ebusR <= brx;
          diagARX: ebusR <= arx;
          default: ebusR <= ad;
        endcase
      end
    end
  end

  // Bus reads zero when not driven
  assign ebusData = ebusDriving ? ebusR : '0;

endmodule

`default_nettype wire

// File: hdl/adderUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module adderUnit
  import edpPkg::*;
(
  input  wire tAdFunc                     adFunc,
  input  wire tAdaSel                     adaSel,
  input  wire tAdbSel                     adbSel,
  input  wire logic                       carryIn,
  input  wire logic [0:`EDP_WORD_BITS-1]  ar,
  input  wire logic [0:`EDP_WORD_BITS-1]  arx,
  input  wire logic [0:`EDP_WORD_BITS-1]  br,
  input  wire logic [0:`EDP_WORD_BITS-1]  brx,
  input  wire logic [0:`EDP_WORD_BITS-1]  mq,
  input  wire logic [0:`EDP_WORD_BITS-1]  fm,
  output logic      [0:`EDP_WORD_BITS-1]  ad,
  output logic                            adCarry,
  output logic                            adOverflow
);

  localparam int W      = `EDP_WORD_BITS;
  localparam int GBITS  = 6;
  localparam int GROUPS = W / GBITS;

  logic [0:W-1] opA, opB, opBeff;
  logic [0:W-1] gen, prop, bitCin, sum;
  logic [0:GROUPS-1] grpG, grpP;
  // carryAt[j] is the carry out of group j, carryAt[GROUPS] is the carry in
  logic [0:GROUPS] carryAt;
  logic cin, arith;

  always_comb begin
    case (adaSel)
      adaAR:   opA = ar;
      adaARX:  opA = arx;
      adaMQ:   opA = mq;
      default: opA = '0;
    endcase
  end

  // Shifted forms pull their low bits from the extension register
  always_comb begin
    case (adbSel)
      adbFM:   opB = fm;
      adbBRx2: opB = {br[1:W-1], brx[0]};
      adbBR:   opB = br;
      default: opB = {ar[2:W-1], arx[0:1]};
    endcase
  end

  assign arith  = (adFunc == adADD) || (adFunc == adSUB) || (adFunc == adINC);
  assign opBeff = (adFunc == adSUB) ? ~opB : (adFunc == adINC) ? '0 : opB;
  assign cin    = (adFunc == adADD) ? carryIn : 1'b1;
  assign gen    = opA & opBeff;
  assign prop   = opA ^ opBeff;

  // 6-bit group generate and propagate
  always_comb begin
    for (int k = 0; k < GROUPS; k++) begin
      grpG[k] = 1'b0;
      grpP[k] = 1'b1;
      for (int i = GBITS * k; i < GBITS * k + GBITS; i++) begin
        grpG[k] = grpG[k] | (grpP[k] & gen[i]);
        grpP[k] = grpP[k] & prop[i];
      end
    end
  end

  // Lookahead stage, sum of products per group
  always_comb begin
    logic term;
    carryAt[GROUPS] = cin;
    for (int j = 0; j < GROUPS; j++) begin
      carryAt[j] = 1'b0;
      for (int m = j; m <= GROUPS; m++) begin
        term = (m == GROUPS) ? cin : grpG[m];
        for (int n = j; n < m; n++) begin
          term = term & grpP[n];
        end
        carryAt[j] = carryAt[j] | term;
      end
    end
  end

  // Ripple within each group from its lookahead carry
  always_comb begin
    for (int k = 0; k < GROUPS; k++) begin
      bitCin[GBITS * k + GBITS - 1] = carryAt[k + 1];
      for (int i = GBITS * k + GBITS - 1; i > GBITS * k; i--) begin
        bitCin[i - 1] = gen[i] | (prop[i] & bitCin[i]);
      end
    end
  end

  assign sum = prop ^ bitCin;

  always_comb begin
    case (adFunc)
      adADD, adSUB, adINC: ad = sum;
      adAND:   ad = opA & opB;
      adOR:    ad = opA | opB;
      adXOR:   ad = opA ^ opB;
      adPASSB: ad = opB;
      adNOTA:  ad = ~opA;
      default: ad = opA;
    endcase
  end

  assign adCarry    = arith & carryAt[0];
  assign adOverflow = arith & (bitCin[0] ^ carryAt[0]);

endmodule

`default_nettype wire

// File: hdl/fastMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module fastMemory (
  input  wire logic                          CLK,
  input  wire logic                          FPGA_RESET,
  input  wire logic [`EDP_FM_ADDR_BITS-1:0]  fmAddr,
  input  wire logic                          fmWriteL,
  input  wire logic                          fmWriteR,
  input  wire logic [0:`EDP_WORD_BITS-1]     ar,
  output logic      [0:`EDP_WORD_BITS-1]     fm,
  output logic                               fmParity
);

  localparam int HALF = `EDP_WORD_BITS / 2;

  // Separate left and right arrays for halfword writes
  logic [0:HALF-1] memL [`EDP_FM_WORDS];
  logic [0:HALF-1] memR [`EDP_FM_WORDS];

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      for (int i = 0; i < `EDP_FM_WORDS; i++) begin
        memL[i] <= '0;
        memR[i] <= '0;
      end
    end else begin
      if (fmWriteL) begin
        memL[fmAddr] <= ar[0:HALF-1];
      end
      if (fmWriteR) begin
        memR[fmAddr] <= ar[HALF:`EDP_WORD_BITS-1];
      end
    end
  end

  // Asynchronous read
  assign fm       = {memL[fmAddr], memR[fmAddr]};
  assign fmParity = ^fm;

endmodule

`default_nettype wire

// File: hdl/mqShifter.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module mqShifter
  import edpPkg::*;
(
  input  wire logic                       CLK,
  input  wire logic                       FPGA_RESET,
  input  wire tMqFunc                     mqFunc,
  input  wire logic [0:`EDP_WORD_BITS-1]  ad,
  input  wire logic                       adCarry,
  output logic      [0:`EDP_WORD_BITS-1]  mq
);

  localparam int LSB = `EDP_WORD_BITS - 1;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      mq <= '0;
    end else begin
      case (mqFunc)
        mqLOAD: mq <= ad;
        // Adder carry enters at the low end
        mqSHL:  mq <= {mq[1:LSB], adCarry};
        // Sign bit is replicated
        mqSHR:  mq <= {mq[0], mq[0:LSB-1]};
        default: mq <= mq;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/operandRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module operandRegs
  import edpPkg::*;
(
  input  wire logic                       CLK,
  input  wire logic                       FPGA_RESET,
  input  wire tArSel                      arSel,
  input  wire logic                       arlLoad,
  input  wire logic                       arrLoad,
  input  wire logic                       arxLoad,
  input  wire logic                       brLoad,
  input  wire logic                       brxLoad,
  input  wire logic [0:`EDP_WORD_BITS-1]  cacheDataRead,
  input  wire logic [0:`EDP_WORD_BITS-1]  ebusIn,
  input  wire logic [0:`EDP_WORD_BITS-1]  ad,
  output logic      [0:`EDP_WORD_BITS-1]  ar,
  output logic      [0:`EDP_WORD_BITS-1]  arx,
  output logic      [0:`EDP_WORD_BITS-1]  br,
  output logic      [0:`EDP_WORD_BITS-1]  brx
);

  localparam int HALF = `EDP_WORD_BITS / 2;

  logic [0:`EDP_WORD_BITS-1] arSrc;

  // AR source mux, shared by both halves
  always_comb begin
    case (arSel)
      arCACHE: arSrc = cacheDataRead;
      arAD:    arSrc = ad;
      arEBUS:  arSrc = ebusIn;
      default: arSrc = '0;
    endcase
  end

  // AR halves load independently
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      ar <= '0;
    end else begin
      if (arlLoad) begin
        ar[0:HALF-1] <= arSrc[0:HALF-1];
      end
      if (arrLoad) begin
        ar[HALF:`EDP_WORD_BITS-1] <= arSrc[HALF:`EDP_WORD_BITS-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      arx <= '0;
    end else if (arxLoad) begin
      arx <= ad;
    end
  end

  // BR and BRX take the old AR and ARX
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      br  <= '0;
      brx <= '0;
    end else begin
      if (brLoad) begin
        br <= ar;
      end
      if (brxLoad) begin
        brx <= arx;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/microDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_config.svh"

module microDecode
  import edpPkg::*;
(
  input  wire logic                         CLK,
  input  wire logic                         FPGA_RESET,
  input  wire logic [`EDP_UWORD_BITS-1:0]   uWord,
  input  wire logic                         adCarry,
  output tAdFunc                            adFunc,
  output tAdaSel                            adaSel,
  output tAdbSel                            adbSel,
  output tArSel                             arSel,
  output logic                              arlLoad,
  output logic                              arrLoad,
  output logic                              arxLoad,
  output logic                              brLoad,
  output logic                              brxLoad,
  output tMqFunc                            mqFunc,
  output logic                              fmWriteL,
  output logic                              fmWriteR,
  output logic [`EDP_FM_ADDR_BITS-1:0]      fmAddr,
  output logic                              carryIn,
  output logic                              adToEbus
);

  logic heldCarry;
  logic [1:0] carryMode;

  // Unused function codes fall back to pass-A
  always_comb begin
    case (uWord[3:0])
      adADD, adSUB, adINC, adAND, adOR, adXOR, adPASSA, adPASSB, adNOTA:
        adFunc = tAdFunc'(uWord[3:0]);
      default:
        adFunc = adPASSA;
    endcase
  end

  assign adaSel    = tAdaSel'(uWord[5:4]);
  assign adbSel    = tAdbSel'(uWord[7:6]);
  assign arSel     = tArSel'(uWord[9:8]);
  assign arlLoad   = uWord[10];
  assign arrLoad   = uWord[11];
  assign arxLoad   = uWord[12];
  assign brLoad    = uWord[13];
  assign brxLoad   = uWord[14];
  assign mqFunc    = tMqFunc'(uWord[16:15]);
  assign fmWriteL  = uWord[17];
  assign fmWriteR  = uWord[18];
  assign fmAddr    = uWord[22:19];
  assign carryMode = uWord[24:23];
  assign adToEbus  = uWord[25];

  // Carry out of the previous microword, for multiword add chains
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      heldCarry <= 1'b0;
    end else begin
      heldCarry <= adCarry;
    end
  end

  always_comb begin
    case (carryMode)
      2'd1:    carryIn = 1'b1;
      2'd2:    carryIn = heldCarry;
      default: carryIn = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/edpPkg.sv
`default_nettype none

package edpPkg;

  // AD function, microword bits 3:0
  typedef enum logic [3:0] {
    adADD   = 4'd0,
    adSUB   = 4'd1,
    adINC   = 4'd2,
    adAND   = 4'd3,
    adOR    = 4'd4,
    adXOR   = 4'd5,
    adPASSA = 4'd6,
    adPASSB = 4'd7,
    adNOTA  = 4'd8
  } tAdFunc;

  // ADA operand select
  typedef enum logic [1:0] {adaAR, adaARX, adaMQ, adaZERO} tAdaSel;

  // ADB operand select
  typedef enum logic [1:0] {adbFM, adbBRx2, adbBR, adbARx4} tAdbSel;

  // AR halfword source
  typedef enum logic [1:0] {arCACHE, arAD, arEBUS, arZERO} tArSel;

  // MQ universal shift register function
  typedef enum logic [1:0] {mqLOAD, mqSHL, mqSHR, mqHOLD} tMqFunc;

  // Diagnostic readback source, codes 6 and 7 both read AD
  typedef enum logic [2:0] {
    diagAR  = 3'd0,
    diagBR  = 3'd1,
    diagMQ  = 3'd2,
    diagFM  = 3'd3,
    diagBRX = 3'd4,
    diagARX = 3'd5,
    diagAD  = 3'd6
  } tDiagSel;

endpackage

`default_nettype wire

// File: hdl/edp_config.svh
`ifndef EDP_CONFIG_SVH
`define EDP_CONFIG_SVH

// Data path word width, bit 0 is the sign bit
`define EDP_WORD_BITS 36

// Fast memory geometry
`define EDP_FM_WORDS 16
`define EDP_FM_ADDR_BITS 4

// One microword per clock
`define EDP_UWORD_BITS 32

`endif
